// File: all.f
nocPkg.sv
portPkg.sv
flitFifo.sv
inputUnit.sv
holdTimer.sv
outputArbiter.sv
outputMux.sv
routerOutput.sv
tbRouterOutput.sv

// File: run.sh
#!/bin/sh
# Compile and run the router output testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps \
  --top-module tbRouterOutput \
  -f all.f \
  -o simRouterOutput
./obj_dir/simRouterOutput

// File: tbRouterOutput.sv
module tbRouterOutput;
  timeunit 1ns;
  timeprecision 1ps;
  import nocPkg::*;
  import portPkg::*;

  localparam int fifoDepth = 8;
  // Flits strobed over all tests add up as 3 + 25 + 10 + 7 + 32 + 6
  localparam int totalFlits = 83;
  localparam int cycleLimit = totalFlits + 200;

  logic clk;
  logic rst;
  linkFlitT [numPorts-1:0] linkIn;
  logic [numPorts-1:0] full;
  outFlitT outFlit;

  flitWordT linkQueue [numPorts][$];
  flitWordT portQueue [numPorts][$];
  flitWordT expWord [$];
  portT expPort [$];
  flitWordT recvWord [$];
  portT recvPort [$];
  int recvCycle [$];
  int headCycle [numPorts];
  int cycleCount;

  routerOutput #(
    .fifoDepth(fifoDepth)
  ) DUT (
    .clk(clk),
    .rst(rst),
    .linkIn(linkIn),
    .full(full),
    .outFlit(outFlit)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial
  begin
    cycleCount = 0;
    while (cycleCount < cycleLimit)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout after %0d cycles, the expected flits never all arrived", cycleCount);
    $display("Finished with errors");
    $fatal(1, "Simulation timed out");
  end

  // One queued flit per port and cycle, so queued packets leave back to back
  initial
  begin
    forever
    begin
      @(posedge clk);
      #2;
      for (int p = 0; p < numPorts; p++)
      begin
        if (linkQueue[p].size() > 0)
        begin
          if (linkQueue[p][0].head.flitId == flitHead)
            headCycle[p] = cycleCount;
          linkIn[p] = {1'b1, linkQueue[p].pop_front()};
        end
        else
          linkIn[p].valid = 1'b0;
      end
    end
  end

  initial
  begin
    forever
    begin
      @(negedge clk);
      if (outFlit.valid === 1'b1)
      begin
        recvWord.push_back(outFlit.word);
        recvPort.push_back(outFlit.srcPort);
        recvCycle.push_back(cycleCount);
      end
    end
  end

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic checkWord(input string name, input flitWordT exp, input flitWordT act);
    if (act !== exp)
      reportFailure($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic checkPort(input string name, input portT exp, input portT act);
    if (act !== exp)
      reportFailure($sformatf("Fail %s: expected %s, actual %s", name, exp.name(), act.name()));
  endtask

  task automatic checkFull(input string name, input logic [numPorts-1:0] exp,
                           input logic [numPorts-1:0] act);
    if (act !== exp)
      reportFailure($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic compareValue(input string name, input int exp, input int act);
    if (act !== exp)
      reportFailure($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic sendPacket(input portT port, input int length, input logic [7:0] destination);
    flitWordT word;
    word.head.flitId = flitHead;
    word.head.length = 12'(length);
    word.head.destination = destination;
    word.head.reserved = '0;
    linkQueue[port].push_back(word);
    portQueue[port].push_back(word);
    for (int i = 1; i < length; i++)
    begin
      word.body.flitId = (i == length - 1) ? flitTail : flitBody;
      word.body.payload = 29'($urandom);
      linkQueue[port].push_back(word);
      portQueue[port].push_back(word);
    end
  endtask

  // A flit that the input unit must discard, so it is not expected anywhere
  task automatic sendRaw(input portT port, input flitIdT id);
    flitWordT word;
    word.body.flitId = id;
    word.body.payload = 29'($urandom);
    linkQueue[port].push_back(word);
  endtask

  task automatic expectFlits(input portT port, input int count);
    for (int i = 0; i < count; i++)
    begin
      expWord.push_back(portQueue[port].pop_front());
      expPort.push_back(port);
    end
  endtask

  task automatic expectPacket(input portT port);
    expectFlits(port, int'(portQueue[port][0].head.length));
  endtask

  task automatic startTest();
    @(negedge clk);
    expWord.delete();
    expPort.delete();
    recvWord.delete();
    recvPort.delete();
    recvCycle.delete();
  endtask

  task automatic waitForFlits();
    while (recvWord.size() < expWord.size())
      @(posedge clk);
    repeat (10) @(posedge clk);
  endtask

  task automatic verifyOutputs(input string name);
    waitForFlits();
    compareValue({name, " flit count"}, expWord.size(), recvWord.size());
    for (int i = 0; i < expWord.size(); i++)
    begin
      checkPort($sformatf("%s port of flit %0d", name, i), expPort[i], recvPort[i]);
      checkWord($sformatf("%s word of flit %0d", name, i), expWord[i], recvWord[i]);
    end
  endtask

  task automatic singlePacket();
    compareValue("reset valid", 0, int'(outFlit.valid));
    checkFull("reset full", '0, full);
    startTest();
    sendPacket(portNorth, 3, 8'h21);
    expectPacket(portNorth);
    verifyOutputs("single");
    compareValue("single latency", 4, recvCycle[0] - headCycle[portNorth]);
  endtask

  // Two packets per port, so the second round wraps from south to local
  task automatic roundRobin();
    startTest();
    for (int p = 0; p < numPorts; p++)
    begin
      sendPacket(portT'(3'(p)), 2, 8'(p));
      sendPacket(portT'(3'(p)), 3, 8'(p + 8));
    end
    for (int r = 0; r < 2; r++)
      for (int p = 0; p < numPorts; p++)
        expectPacket(portT'(3'(p)));
    verifyOutputs("roundRobin");
  endtask

  task automatic holdLength();
    startTest();
    sendPacket(portEast, 2, 8'h31);
    sendPacket(portEast, 5, 8'h32);
    sendPacket(portWest, 3, 8'h41);
    expectPacket(portEast);
    expectPacket(portWest);
    expectPacket(portEast);
    verifyOutputs("holdLength");
    // The second east packet holds the grant for five cycles in a row
    compareValue("holdLength east hold", 4, recvCycle[9] - recvCycle[5]);
  endtask

  task automatic framing();
    startTest();
    sendRaw(portSouth, flitBody);
    sendRaw(portSouth, flitTail);
    sendRaw(portSouth, flitIdle);
    sendPacket(portSouth, 4, 8'h51);
    expectPacket(portSouth);
    verifyOutputs("framing");
  endtask

  task automatic fullAndDrop();
    startTest();
    sendPacket(portLocal, 20, 8'h61);
    sendPacket(portNorth, 12, 8'h62);
    while (linkQueue[portNorth].size() > 0)
      @(posedge clk);
    repeat (2) @(negedge clk);
    checkFull("fullAndDrop full", 5'b00010, full);
    // Only the first fifoDepth north flits fit and the rest are dropped
    while (portQueue[portNorth].size() > fifoDepth)
      void'(portQueue[portNorth].pop_back());
    expectPacket(portLocal);
    expectFlits(portNorth, fifoDepth);
    verifyOutputs("fullAndDrop");
    checkFull("fullAndDrop drained", '0, full);
  endtask

  task automatic unionViews();
    startTest();
    sendPacket(portWest, 6, 8'h5a);
    expectPacket(portWest);
    waitForFlits();
    compareValue("union flit count", expWord.size(), recvWord.size());
    for (int i = 0; i < expWord.size(); i++)
    begin
      checkPort($sformatf("union port of flit %0d", i), portWest, recvPort[i]);
      compareValue($sformatf("union id of flit %0d", i), int'(expWord[i].head.flitId),
                   int'(recvWord[i].head.flitId));
      if (i == 0)
      begin
        compareValue("union length", 6, int'(recvWord[i].head.length));
        compareValue("union destination", 'h5a, int'(recvWord[i].head.destination));
      end
      else
        compareValue($sformatf("union payload of flit %0d", i),
                     int'(expWord[i].body.payload), int'(recvWord[i].body.payload));
    end
  endtask

  initial
  begin
    rst = 1'b1;
    linkIn = '0;
    void'($urandom(32'heb32_281d));
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    singlePacket();
    roundRobin();
    holdLength();
    framing();
    fullAndDrop();
    unionViews();
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: routerOutput.sv
module routerOutput #(
  parameter int fifoDepth = 8
) (
  input logic clk,
  input logic rst,
  input nocPkg::linkFlitT [portPkg::numPorts-1:0] linkIn,
  output logic [portPkg::numPorts-1:0] full,
  output portPkg::outFlitT outFlit
);
  import nocPkg::*;
  import portPkg::*;

  logic [numPorts-1:0] wrEn;
  flitWordT [numPorts-1:0] wrWord;
  flitWordT [numPorts-1:0] front;
  logic [numPorts-1:0] notEmpty;
  logic [numPorts-1:0] sendGrant;

  // One input unit and one FIFO per link, in portT order
  for (genvar i = 0; i < numPorts; i++)
  begin : genPort
    inputUnit unitInst (
      .clk(clk),
      .rst(rst),
      .linkIn(linkIn[i]),
      .full(full[i]),
      .wrEn(wrEn[i]),
      .wrWord(wrWord[i])
    );

    flitFifo #(
      .fifoDepth(fifoDepth)
    ) fifoInst (
      .clk(clk),
      .rst(rst),
      .wrEn(wrEn[i]),
      .wrWord(wrWord[i]),
      .rdEn(sendGrant[i]),
      .front(front[i]),
      .notEmpty(notEmpty[i]),
      .full(full[i])
    );
  end

  outputArbiter arbiterInst (
    .clk(clk),
    .rst(rst),
    .front(front),
    .notEmpty(notEmpty),
    .sendGrant(sendGrant)
  );

  outputMux muxInst (
    .clk(clk),
    .rst(rst),
    .front(front),
    .sendGrant(sendGrant),
    .outFlit(outFlit)
  );

endmodule

// File: outputMux.sv
module outputMux (
  input logic clk,
  input logic rst,
  input nocPkg::flitWordT [portPkg::numPorts-1:0] front,
  input logic [portPkg::numPorts-1:0] sendGrant,
  output portPkg::outFlitT outFlit
);
  import portPkg::*;

  portT selPort;
  logic anyGrant;

  // The grant is one-hot, so the loop simply finds its set bit
  always_comb
  begin
    selPort = portLocal;
    anyGrant = 1'b0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (sendGrant[i])
      begin
        selPort = portT'(3'(i));
        anyGrant = 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit.valid <= 1'b0;
    end
    else
    begin
      outFlit.valid <= anyGrant;
      if (anyGrant)
      begin
        outFlit.srcPort <= selPort;
        outFlit.word <= front[selPort];
      end
    end
  end

endmodule

// File: outputArbiter.sv
module outputArbiter (
  input logic clk,
  input logic rst,
  input nocPkg::flitWordT [portPkg::numPorts-1:0] front,
  input logic [portPkg::numPorts-1:0] notEmpty,
  output logic [portPkg::numPorts-1:0] sendGrant
);
  import portPkg::*;

  grantT state;
  grantT nextState;
  logic [numPorts-1:0] timesUp;
  logic portState;
  int curPort;

  // First ready port found by a cyclic search that begins at start
  function automatic grantT firstReady(input logic [numPorts-1:0] ready, input int start);
    int idx;
    grantT pick;
    pick = grantIdle;
    for (int k = numPorts - 1; k >= 0; k--)
    begin
      idx = (start + k) % numPorts;
      if (ready[idx])
        pick = grantT'(6'b000010 << idx);
    end
    return pick;
  endfunction

  for (genvar i = 0; i < numPorts; i++)
  begin : genTimer
    holdTimer timerInst (
      .clk(clk),
      .rst(rst),
      .front(front[i]),
      .runTimer(sendGrant[i]),
      .timesUp(timesUp[i])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= grantIdle;
    else
      state <= nextState;
  end

  always_comb
  begin
    portState = 1'b1;
    curPort = 0;
    case (state)
      grantLocal: curPort = 0;
      grantNorth: curPort = 1;
      grantEast: curPort = 2;
      grantWest: curPort = 3;
      grantSouth: curPort = 4;
      default: portState = 1'b0;
    endcase
  end

  // The held port is the last candidate when its packet ends
  always_comb
  begin
    sendGrant = '0;
    if (state == grantIdle)
    begin
      nextState = firstReady(notEmpty, 0);
    end
    else if (!portState)
    begin
      nextState = grantIdle;
    end
    else if (notEmpty[curPort] && !timesUp[curPort])
    begin
      sendGrant[curPort] = 1'b1;
      nextState = state;
    end
    else
    begin
      nextState = firstReady(notEmpty, curPort + 1);
    end
  end

endmodule

// File: holdTimer.sv
module holdTimer (
  input logic clk,
  input logic rst,
  input nocPkg::flitWordT front,
  input logic runTimer,
  output logic timesUp
);
  import nocPkg::*;

  logic [lengthWidth-1:0] count;
  logic [lengthWidth-1:0] holdLength;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
      holdLength <= '0;
    end
    else
    begin
      // A waiting head loads its length before the grant starts counting
      if (front.head.flitId == flitHead && !runTimer)
        holdLength <= front.head.length;
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == holdLength);

endmodule

// File: inputUnit.sv
module inputUnit (
  input logic clk,
  input logic rst,
  input nocPkg::linkFlitT linkIn,
  input logic full,
  output logic wrEn,
  output nocPkg::flitWordT wrWord
);
  import nocPkg::*;

  flitIdT linkId;
  logic inPacket;
  logic accept;

  assign linkId = linkIn.word.head.flitId;

  // Body and tail flits only pass inside an open packet
  always_comb
  begin
    accept = 1'b0;
    if (linkIn.valid && !full)
    begin
      case (linkId)
        flitHead: accept = 1'b1;
        flitBody, flitTail: accept = inPacket;
        default: accept = 1'b0;
      endcase
    end
  end

  // Framing follows the link itself, so a dropped head still opens a packet
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      inPacket <= 1'b0;
      wrEn <= 1'b0;
    end
    else
    begin
      wrEn <= accept;
      if (linkIn.valid && linkId == flitHead)
        inPacket <= 1'b1;
      else if (linkIn.valid && linkId == flitTail)
        inPacket <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    wrWord <= linkIn.word;
  end

endmodule

// File: flitFifo.sv
module flitFifo #(
  parameter int fifoDepth = 8
) (
  input logic clk,
  input logic rst,
  input logic wrEn,
  input nocPkg::flitWordT wrWord,
  input logic rdEn,
  output nocPkg::flitWordT front,
  output logic notEmpty,
  output logic full
);
  import nocPkg::*;

  localparam int ptrWidth = $clog2(fifoDepth);
  localparam logic [ptrWidth:0] maxCount = (ptrWidth + 1)'(fifoDepth);

  flitWordT mem [fifoDepth];
  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth:0] count;
  logic doWrite;
  logic doRead;

  assign doWrite = wrEn && !full;
  assign doRead = rdEn && notEmpty;

  // Pointers wrap on their own because the depth is a power of two
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= wrPtr + 1'b1;
      if (doRead)
        rdPtr <= rdPtr + 1'b1;
      if (doWrite && !doRead)
        count <= count + 1'b1;
      else if (doRead && !doWrite)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (doWrite)
      mem[wrPtr] <= wrWord;
  end

  assign front = mem[rdPtr];
  assign notEmpty = (count != '0);
  assign full = (count == maxCount);

endmodule

// File: portPkg.sv
package portPkg;

  localparam int numPorts = 5;

  typedef enum logic [2:0] {
    portLocal = 3'd0,
    portNorth = 3'd1,
    portEast = 3'd2,
    portWest = 3'd3,
    portSouth = 3'd4
  } portT;

  // Bit 0 is idle, bits 1 to 5 follow portT order
  typedef enum logic [5:0] {
    grantIdle = 6'b000001,
    grantLocal = 6'b000010,
    grantNorth = 6'b000100,
    grantEast = 6'b001000,
    grantWest = 6'b010000,
    grantSouth = 6'b100000
  } grantT;

  typedef struct packed {
    logic valid;
    portT srcPort;
    nocPkg::flitWordT word;
  } outFlitT;

endpackage

// File: nocPkg.sv
package nocPkg;

  localparam int flitWidth = 32;
  localparam int idWidth = 3;
  localparam int lengthWidth = 12;
  localparam int destWidth = 8;
  localparam int payloadWidth = flitWidth - idWidth;

  typedef enum logic [idWidth-1:0] {
    flitIdle = 3'd0,
    flitHead = 3'd1,
    flitBody = 3'd2,
    flitTail = 3'd3
  } flitIdT;

  // Length counts every flit of the packet, the head included
  typedef struct packed {
    flitIdT flitId;
    logic [lengthWidth-1:0] length;
    logic [destWidth-1:0] destination;
    logic [8:0] reserved;
  } headFieldsT;

  typedef struct packed {
    flitIdT flitId;
    logic [payloadWidth-1:0] payload;
  } bodyFieldsT;

  // Both views keep flitId in the top bits, so either one can read it
  typedef union packed {
    headFieldsT head;
    bodyFieldsT body;
  } flitWordT;

  typedef struct packed {
    logic valid;
    flitWordT word;
  } linkFlitT;

endpackage
